//--- src/axi_remap_pkg.sv
// Shared widths and reduced AXI4 channel types for the remap stage; imported by every RTL module
package axi_remap_pkg;

  // Bus widths
  localparam int unsigned addr_width = 32;
  localparam int unsigned data_width = 32;
  localparam int unsigned strb_width = data_width / 8;
  localparam int unsigned id_width   = 4;
  localparam int unsigned len_width  = 8;

  // Outstanding transactions allowed per direction
  localparam int unsigned max_outstanding = 15;
  // Counter must hold max_outstanding
  localparam int unsigned cnt_width = 4;

  typedef logic [addr_width-1:0] addr_t;
  typedef logic [data_width-1:0] data_t;
  typedef logic [strb_width-1:0] strb_t;
  typedef logic [id_width-1:0]   id_t;
  typedef logic [len_width-1:0]  len_t;

  // Response code, only the two values used here
  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_slverr = 2'b10
  } axi_resp_e;

  // Write address channel, 44 bits
  typedef struct packed {
    id_t   id;
    addr_t addr;
    len_t  len;
  } aw_chan_t;

  // Write data channel
  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
  } w_chan_t;

  // Write response channel
  typedef struct packed {
    id_t       id;
    axi_resp_e resp;
  } b_chan_t;

  // Read address channel, same layout as AW
  typedef struct packed {
    id_t   id;
    addr_t addr;
    len_t  len;
  } ar_chan_t;

  // Read data channel
  typedef struct packed {
    id_t       id;
    data_t     data;
    axi_resp_e resp;
    logic      last;
  } r_chan_t;

  // Everything driven by the manager
  typedef struct packed {
    aw_chan_t aw;
    logic     aw_valid;
    w_chan_t  w;
    logic     w_valid;
    logic     b_ready;
    ar_chan_t ar;
    logic     ar_valid;
    logic     r_ready;
  } axi_req_t;

  // Everything driven by the subordinate
  typedef struct packed {
    logic    aw_ready;
    logic    w_ready;
    b_chan_t b;
    logic    b_valid;
    logic    ar_ready;
    r_chan_t r;
    logic    r_valid;
  } axi_rsp_t;

  // One region of the remap table, 97 bits
  typedef struct packed {
    logic  valid;
    // Compared against the masked address
    addr_t base;
    // Bits that select the region and get replaced
    addr_t mask;
    addr_t target;
  } remap_entry_t;

endpackage

//--- src/axi_modify_address.sv
// Request copy with substituted AW and AR addresses; the response passes back untouched
`timescale 1ns/1ps

module axi_modify_address (
  // Slave side
  input  axi_remap_pkg::axi_req_t slv_req_i,
  output axi_remap_pkg::axi_rsp_t slv_rsp_o,
  // Replacement addresses, held stable by the caller while a handshake is pending
  input  axi_remap_pkg::addr_t    mst_aw_addr_i,
  input  axi_remap_pkg::addr_t    mst_ar_addr_i,
  // Master side
  output axi_remap_pkg::axi_req_t mst_req_o,
  input  axi_remap_pkg::axi_rsp_t mst_rsp_i
);
  import axi_remap_pkg::*;

  aw_chan_t mst_aw;
  ar_chan_t mst_ar;

  // Keep id and len, swap only the address
  always_comb begin
    mst_aw      = slv_req_i.aw;
    mst_aw.addr = mst_aw_addr_i;
    mst_ar      = slv_req_i.ar;
    mst_ar.addr = mst_ar_addr_i;
  end

  // Valids, W payload and response readies go straight through
  assign mst_req_o = '{
    aw:       mst_aw,
    aw_valid: slv_req_i.aw_valid,
    w:        slv_req_i.w,
    w_valid:  slv_req_i.w_valid,
    b_ready:  slv_req_i.b_ready,
    ar:       mst_ar,
    ar_valid: slv_req_i.ar_valid,
    r_ready:  slv_req_i.r_ready
  };

  // Responses are never altered
  assign slv_rsp_o = mst_rsp_i;

endmodule

//--- src/axi_remap_table.sv
// Programmable region table with parallel priority lookup of the AW and AR addresses
`timescale 1ns/1ps

module axi_remap_table #(
  parameter int unsigned num_regions = 4
) (
  input  logic                         clk_i,
  input  logic                         rst_i,
  // Single-entry write port from the controller
  input  logic                         we_i,
  input  logic [$clog2(num_regions)-1:0] idx_i,
  input  axi_remap_pkg::remap_entry_t  entry_i,
  // Untranslated addresses
  input  axi_remap_pkg::addr_t         aw_addr_i,
  input  axi_remap_pkg::addr_t         ar_addr_i,
  // Translated addresses, combinational
  output axi_remap_pkg::addr_t         aw_addr_o,
  output axi_remap_pkg::addr_t         ar_addr_o
);
  import axi_remap_pkg::*;

  remap_entry_t entries [num_regions];

  // Region hit test
  function automatic logic region_hit(remap_entry_t e, addr_t a);
    return e.valid && ((a & e.mask) == e.base);
  endfunction

  // Masked bits from target, the rest from the original address
  function automatic addr_t region_apply(remap_entry_t e, addr_t a);
    return (e.target & e.mask) | (a & ~e.mask);
  endfunction

  // Reset invalidates every entry and we_i replaces one
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < num_regions; i++) begin
        entries[i].valid <= 1'b0;
      end
    end else if (we_i) begin
      entries[idx_i] <= entry_i;
    end
  end

  // Scan from the top down so the lowest matching index is applied last
  always_comb begin
    aw_addr_o = aw_addr_i;
    ar_addr_o = ar_addr_i;
    for (int i = num_regions - 1; i >= 0; i--) begin
      if (region_hit(entries[i], aw_addr_i)) begin
        aw_addr_o = region_apply(entries[i], aw_addr_i);
      end
      if (region_hit(entries[i], ar_addr_i)) begin
        ar_addr_o = region_apply(entries[i], ar_addr_i);
      end
    end
  end

  // No hit leaves the address unchanged

endmodule

//--- src/axi_txn_tracker.sv
// Outstanding read and write counter that gates new AW and AR requests and reports bus idle
`timescale 1ns/1ps

module axi_txn_tracker (
  input  logic                    clk_i,
  input  logic                    rst_i,
  // Stop accepting new address requests
  input  logic                    hold_i,
  // Slave side
  input  axi_remap_pkg::axi_req_t slv_req_i,
  output axi_remap_pkg::axi_rsp_t slv_rsp_o,
  // Gated side toward the address modifier
  output axi_remap_pkg::axi_req_t gated_req_o,
  input  axi_remap_pkg::axi_rsp_t gated_rsp_i,
  // No transaction in flight and none half presented
  output logic                    idle_o
);
  import axi_remap_pkg::*;

  logic [cnt_width-1:0] wr_cnt;
  logic [cnt_width-1:0] rd_cnt;
  logic                 aw_open;
  logic                 ar_open;
  logic                 aw_mask;
  logic                 ar_mask;
  logic                 aw_hs;
  logic                 ar_hs;
  logic                 b_hs;
  logic                 r_last_hs;

  // Mask on hold or full counter, but never cut an open request
  assign aw_mask = (hold_i || (wr_cnt == cnt_width'(max_outstanding))) && !aw_open;
  assign ar_mask = (hold_i || (rd_cnt == cnt_width'(max_outstanding))) && !ar_open;

  // Forward everything, then kill valid and ready of a masked channel
  always_comb begin
    gated_req_o          = slv_req_i;
    gated_req_o.aw_valid = slv_req_i.aw_valid && !aw_mask;
    gated_req_o.ar_valid = slv_req_i.ar_valid && !ar_mask;
    slv_rsp_o            = gated_rsp_i;
    slv_rsp_o.aw_ready   = gated_rsp_i.aw_ready && !aw_mask;
    slv_rsp_o.ar_ready   = gated_rsp_i.ar_ready && !ar_mask;
  end

  // Handshakes as seen downstream of the gate
  assign aw_hs     = gated_req_o.aw_valid && gated_rsp_i.aw_ready;
  assign ar_hs     = gated_req_o.ar_valid && gated_rsp_i.ar_ready;
  assign b_hs      = gated_rsp_i.b_valid && gated_req_o.b_ready;
  assign r_last_hs = gated_rsp_i.r_valid && gated_req_o.r_ready && gated_rsp_i.r.last;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_cnt  <= '0;
      rd_cnt  <= '0;
      aw_open <= 1'b0;
      ar_open <= 1'b0;
    end else begin
      // Writes live from AW to B
      wr_cnt  <= wr_cnt + cnt_width'(aw_hs) - cnt_width'(b_hs);
      // Reads live from AR to the last R beat
      rd_cnt  <= rd_cnt + cnt_width'(ar_hs) - cnt_width'(r_last_hs);
      // Presented but not yet taken
      aw_open <= gated_req_o.aw_valid && !gated_rsp_i.aw_ready;
      ar_open <= gated_req_o.ar_valid && !gated_rsp_i.ar_ready;
    end
  end

  // Safe point for a table update
  assign idle_o = (wr_cnt == '0) && (rd_cnt == '0) && !aw_open && !ar_open;

endmodule

//--- src/axi_remap_ctrl.sv
// Configuration FSM that holds the bus, waits for it to drain, then writes one table entry
`timescale 1ns/1ps

module axi_remap_ctrl #(
  parameter int unsigned num_regions = 4
) (
  input  logic                           clk_i,
  input  logic                           rst_i,
  // Configuration port
  input  logic                           cfg_we_i,
  input  logic [$clog2(num_regions)-1:0] cfg_idx_i,
  input  axi_remap_pkg::remap_entry_t    cfg_entry_i,
  output logic                           cfg_busy_o,
  // Tracker interface
  input  logic                           idle_i,
  output logic                           hold_o,
  // Table write port
  output logic                           tbl_we_o,
  output logic [$clog2(num_regions)-1:0] tbl_idx_o,
  output axi_remap_pkg::remap_entry_t    tbl_entry_o
);
  import axi_remap_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_hold,
    st_write
  } state_e;

  state_e                         state_q;
  state_e                         state_d;
  logic [$clog2(num_regions)-1:0] idx_q;
  remap_entry_t                   entry_q;

  // Next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle:  if (cfg_we_i) state_d = st_hold;
      // Wait for the tracker to drain
      st_hold:  if (idle_i) state_d = st_write;
      // Exactly one cycle
      st_write: state_d = st_idle;
      default:  state_d = st_idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= st_idle;
    end else begin
      state_q <= state_d;
    end
  end

  // Capture request only when accepted, strobes while busy are dropped
  always_ff @(posedge clk_i) begin
    if ((state_q == st_idle) && cfg_we_i) begin
      idx_q   <= cfg_idx_i;
      entry_q <= cfg_entry_i;
    end
  end

  // Busy and hold cover both HOLD and WRITE
  assign cfg_busy_o  = (state_q != st_idle);
  assign hold_o      = (state_q != st_idle);
  assign tbl_we_o    = (state_q == st_write);
  assign tbl_idx_o   = idx_q;
  assign tbl_entry_o = entry_q;

endmodule

//--- src/axi_remap_top.sv
// Top level of the AXI address remap stage: tracker, region table, address modifier, controller
`timescale 1ns/1ps

module axi_remap_top #(
  parameter int unsigned num_regions = 4
) (
  input  logic                           clk_i,
  input  logic                           rst_i,
  // Slave side, from the manager
  input  axi_remap_pkg::axi_req_t        slv_req_i,
  output axi_remap_pkg::axi_rsp_t        slv_rsp_o,
  // Master side, to the subordinate
  output axi_remap_pkg::axi_req_t        mst_req_o,
  input  axi_remap_pkg::axi_rsp_t        mst_rsp_i,
  // Table configuration
  input  logic                           cfg_we_i,
  input  logic [$clog2(num_regions)-1:0] cfg_idx_i,
  input  axi_remap_pkg::remap_entry_t    cfg_entry_i,
  output logic                           cfg_busy_o
);
  import axi_remap_pkg::*;

  // Request after masking, response before masking
  axi_req_t                       gated_req;
  axi_rsp_t                       gated_rsp;
  // Translated addresses
  addr_t                          mst_aw_addr;
  addr_t                          mst_ar_addr;
  // Control between FSM, tracker and table
  logic                           hold;
  logic                           idle;
  logic                           tbl_we;
  logic [$clog2(num_regions)-1:0] tbl_idx;
  remap_entry_t                   tbl_entry;

  // Gates AW/AR under hold and counts what is in flight
  axi_txn_tracker axi_txn_tracker_inst (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .hold_i      (hold),
    .slv_req_i   (slv_req_i),
    .slv_rsp_o   (slv_rsp_o),
    .gated_req_o (gated_req),
    .gated_rsp_i (gated_rsp),
    .idle_o      (idle)
  );

  // Lookup works on the gated addresses
  axi_remap_table #(
    .num_regions (num_regions)
  ) axi_remap_table_inst (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .we_i      (tbl_we),
    .idx_i     (tbl_idx),
    .entry_i   (tbl_entry),
    .aw_addr_i (gated_req.aw.addr),
    .ar_addr_i (gated_req.ar.addr),
    .aw_addr_o (mst_aw_addr),
    .ar_addr_o (mst_ar_addr)
  );

  axi_modify_address axi_modify_address_inst (
    .slv_req_i     (gated_req),
    .slv_rsp_o     (gated_rsp),
    .mst_aw_addr_i (mst_aw_addr),
    .mst_ar_addr_i (mst_ar_addr),
    .mst_req_o     (mst_req_o),
    .mst_rsp_i     (mst_rsp_i)
  );

  // Sequences hold, drain and table write
  axi_remap_ctrl #(
    .num_regions (num_regions)
  ) axi_remap_ctrl_inst (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .cfg_we_i    (cfg_we_i),
    .cfg_idx_i   (cfg_idx_i),
    .cfg_entry_i (cfg_entry_i),
    .cfg_busy_o  (cfg_busy_o),
    .idle_i      (idle),
    .hold_o      (hold),
    .tbl_we_o    (tbl_we),
    .tbl_idx_o   (tbl_idx),
    .tbl_entry_o (tbl_entry)
  );

endmodule

//--- test/axi_remap_mem.sv
// Subordinate memory model for the remap testbench, 256 words with a settable read delay
`timescale 1ns/1ps

module axi_remap_mem (
  input  logic                    clk_i,
  input  logic                    rst_i,
  // Cycles between AR acceptance and the first R beat
  input  logic [7:0]              r_delay_i,
  input  axi_remap_pkg::axi_req_t req_i,
  output axi_remap_pkg::axi_rsp_t rsp_o
);
  import axi_remap_pkg::*;

  data_t      mem [256];
  // Write side, one burst at a time
  logic       wr_act;
  logic       b_pend;
  addr_t      wr_addr;
  id_t        wr_id;
  // Read side, one burst at a time
  logic       rd_act;
  addr_t      rd_addr;
  id_t        rd_id;
  len_t       rd_left;
  logic [7:0] rd_wait;

  always_comb begin
    rsp_o          = '0;
    // AW only when no write burst or B is pending
    rsp_o.aw_ready = !wr_act && !b_pend;
    rsp_o.w_ready  = wr_act;
    rsp_o.b_valid  = b_pend;
    rsp_o.b.id     = wr_id;
    rsp_o.b.resp   = resp_okay;
    rsp_o.ar_ready = !rd_act;
    // R appears once the delay has run out
    rsp_o.r_valid  = rd_act && (rd_wait == 8'd0);
    rsp_o.r.id     = rd_id;
    rsp_o.r.data   = mem[rd_addr[9:2]];
    rsp_o.r.resp   = resp_okay;
    rsp_o.r.last   = (rd_left == '0);
  end

  // Byte-wise write, indexed by the low address bits
  always_ff @(posedge clk_i) begin
    if (req_i.w_valid && rsp_o.w_ready) begin
      for (int b = 0; b < strb_width; b++) begin
        if (req_i.w.strb[b]) begin
          mem[wr_addr[9:2]][8*b +: 8] <= req_i.w.data[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_act  <= 1'b0;
      b_pend  <= 1'b0;
      rd_act  <= 1'b0;
      rd_wait <= 8'd0;
    end else begin
      if (req_i.aw_valid && rsp_o.aw_ready) begin
        wr_act  <= 1'b1;
        wr_addr <= req_i.aw.addr;
        wr_id   <= req_i.aw.id;
      end
      if (req_i.w_valid && rsp_o.w_ready) begin
        wr_addr <= wr_addr + 32'd4;
        if (req_i.w.last) begin
          wr_act <= 1'b0;
          b_pend <= 1'b1;
        end
      end
      if (rsp_o.b_valid && req_i.b_ready) begin
        b_pend <= 1'b0;
      end
      if (req_i.ar_valid && rsp_o.ar_ready) begin
        rd_act  <= 1'b1;
        rd_addr <= req_i.ar.addr;
        rd_id   <= req_i.ar.id;
        rd_left <= req_i.ar.len;
        rd_wait <= r_delay_i;
      end else if (rd_act && (rd_wait != 8'd0)) begin
        rd_wait <= rd_wait - 8'd1;
      end else if (rsp_o.r_valid && req_i.r_ready) begin
        // Next beat or end of burst
        rd_addr <= rd_addr + 32'd4;
        rd_left <= rd_left - 8'd1;
        if (rd_left == '0) begin
          rd_act <= 1'b0;
        end
      end
    end
  end

endmodule

//--- test/axi_remap_tb.sv
// Directed testbench for the AXI remap stage, run from the file list with axi_remap_tb as top
`timescale 1ns/1ps

module axi_remap_tb;
  import axi_remap_pkg::*;

  localparam int num_regions = 4;
  // Writes, reads and table updates issued over all tests
  localparam int num_txns = 110;
  localparam int timeout_limit = 40 * num_txns + 200;

  logic         clk;
  logic         rst;
  axi_req_t     slv_req;
  axi_rsp_t     slv_rsp;
  axi_req_t     mst_req;
  axi_rsp_t     mst_rsp;
  logic         cfg_we;
  logic [1:0]   cfg_idx;
  remap_entry_t cfg_entry;
  logic         cfg_busy;
  logic [7:0]   r_delay;

  // Reference copy of the region table
  logic  m_valid  [num_regions];
  addr_t m_base   [num_regions];
  addr_t m_mask   [num_regions];
  addr_t m_target [num_regions];

  int seed = 84435;
  int cycle_cnt = 0;
  int addr_errs = 0;
  int data_errs = 0;
  int resp_errs = 0;
  int cycle_errs = 0;
  int proto_errs = 0;

  axi_remap_top #(
    .num_regions (num_regions)
  ) axi_remap_top_inst (
    .clk_i       (clk),
    .rst_i       (rst),
    .slv_req_i   (slv_req),
    .slv_rsp_o   (slv_rsp),
    .mst_req_o   (mst_req),
    .mst_rsp_i   (mst_rsp),
    .cfg_we_i    (cfg_we),
    .cfg_idx_i   (cfg_idx),
    .cfg_entry_i (cfg_entry),
    .cfg_busy_o  (cfg_busy)
  );

  // Master-side target
  axi_remap_mem axi_remap_mem_inst (
    .clk_i     (clk),
    .rst_i     (rst),
    .r_delay_i (r_delay),
    .req_i     (mst_req),
    .rsp_o     (mst_rsp)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  // Hard stop if a handshake never completes
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= timeout_limit) begin
      $display("Timeout: run stopped after %0d cycles", cycle_cnt);
      $display("Simulation FAILED");
      $finish;
    end
  end

  task automatic check_addr(input addr_t got, input addr_t exp, input string what);
    if (got !== exp) begin
      addr_errs++;
      $display("Error at %0t: %s address 0x%08h, expected 0x%08h", $time, what, got, exp);
    end
  endtask

  task automatic check_data(input data_t got, input data_t exp, input string what);
    if (got !== exp) begin
      data_errs++;
      $display("Error at %0t: %s data 0x%08h, expected 0x%08h", $time, what, got, exp);
    end
  endtask

  task automatic check_resp(input axi_resp_e got, input axi_resp_e exp, input string what);
    if (got !== exp) begin
      resp_errs++;
      $display("Error at %0t: %s response %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_cycles(input int got, input int exp, input string what);
    if (got != exp) begin
      cycle_errs++;
      $display("Error at %0t: %s lasted %0d cycles, expected %0d", $time, what, got, exp);
    end
  endtask

  // Translation rule: first valid hit in index order replaces the masked bits
  function automatic addr_t expected_addr(input addr_t a);
    addr_t res;
    logic  found;
    res = a;
    found = 1'b0;
    for (int i = 0; i < num_regions; i++) begin
      if (!found && m_valid[i] && ((a & m_mask[i]) == m_base[i])) begin
        res = (a & ~m_mask[i]) | (m_target[i] & m_mask[i]);
        found = 1'b1;
      end
    end
    return res;
  endfunction

  function automatic remap_entry_t entry_of(input addr_t base, input addr_t mask, input addr_t tgt);
    return '{valid: 1'b1, base: base, mask: mask, target: tgt};
  endfunction

  task automatic model_update(input int idx, input remap_entry_t e);
    m_valid[idx]  = e.valid;
    m_base[idx]   = e.base;
    m_mask[idx]   = e.mask;
    m_target[idx] = e.target;
  endtask

  // Table update on an idle bus, busy must last exactly two cycles
  task automatic program_region(input int idx, input remap_entry_t e);
    int busy_cycles;
    busy_cycles = 0;
    @(posedge clk);
    cfg_we    <= 1'b1;
    cfg_idx   <= idx[1:0];
    cfg_entry <= e;
    @(posedge clk);
    cfg_we <= 1'b0;
    do begin
      @(posedge clk);
      if (cfg_busy) begin
        busy_cycles++;
      end
    end while (cfg_busy);
    check_cycles(busy_cycles, 2, "cfg busy");
    model_update(idx, e);
  endtask

  // Single-beat write, AW and W presented together
  task automatic write_word(input addr_t a, input data_t d, output addr_t mst_addr,
                            output axi_resp_e resp);
    logic got_b;
    got_b = 1'b0;
    @(posedge clk);
    slv_req.aw       <= '{id: 4'h1, addr: a, len: 8'd0};
    slv_req.aw_valid <= 1'b1;
    slv_req.w        <= '{data: d, strb: '1, last: 1'b1};
    slv_req.w_valid  <= 1'b1;
    while (!got_b) begin
      @(posedge clk);
      if (slv_req.aw_valid && slv_rsp.aw_ready) begin
        mst_addr = mst_req.aw.addr;
        slv_req.aw_valid <= 1'b0;
      end
      if (slv_req.w_valid && slv_rsp.w_ready) begin
        slv_req.w_valid <= 1'b0;
      end
      if (slv_rsp.b_valid) begin
        resp = slv_rsp.b.resp;
        got_b = 1'b1;
      end
    end
  endtask

  // Single-beat read, r_ready is held high all along
  task automatic read_word(input addr_t a, output addr_t mst_addr, output data_t d,
                           output axi_resp_e resp);
    logic got_r;
    got_r = 1'b0;
    @(posedge clk);
    slv_req.ar       <= '{id: 4'h2, addr: a, len: 8'd0};
    slv_req.ar_valid <= 1'b1;
    while (!got_r) begin
      @(posedge clk);
      if (slv_req.ar_valid && slv_rsp.ar_ready) begin
        mst_addr = mst_req.ar.addr;
        slv_req.ar_valid <= 1'b0;
      end
      if (slv_rsp.r_valid && slv_rsp.r.last) begin
        d = slv_rsp.r.data;
        resp = slv_rsp.r.resp;
        got_r = 1'b1;
      end
    end
  endtask

  // Write then read back, checking both master addresses
  task automatic verify_roundtrip(input addr_t a, input data_t d);
    addr_t     mst_addr;
    data_t     got;
    axi_resp_e resp;
    write_word(a, d, mst_addr, resp);
    check_addr(mst_addr, expected_addr(a), "AW");
    check_resp(resp, resp_okay, "B");
    read_word(a, mst_addr, got, resp);
    check_addr(mst_addr, expected_addr(a), "AR");
    check_data(got, d, "R");
    check_resp(resp, resp_okay, "R");
  endtask

  task automatic passthrough_test();
    verify_roundtrip(32'h0000_0010, $random(seed));
    verify_roundtrip(32'h1000_0040, $random(seed));
    verify_roundtrip(32'h2345_6788, $random(seed));
    verify_roundtrip(32'hFFFF_FFFC, $random(seed));
  endtask

  task automatic single_region_test();
    program_region(0, entry_of(32'h1000_0000, 32'hF000_0000, 32'h8000_0000));
    verify_roundtrip(32'h1000_0040, $random(seed));
    verify_roundtrip(32'h1ABC_0100, $random(seed));
    // Outside the region
    verify_roundtrip(32'h2000_0080, $random(seed));
    verify_roundtrip(32'h0FFF_FFF0, $random(seed));
  endtask

  // Region 1 lies inside region 0, so region 0 must win
  task automatic overlap_test();
    program_region(1, entry_of(32'h1000_0000, 32'hFF00_0000, 32'h4400_0000));
    verify_roundtrip(32'h1000_0080, $random(seed));
    verify_roundtrip(32'h1100_00C0, $random(seed));
  endtask

  // Update requested while a slow read is still outstanding
  task automatic update_under_load_test();
    addr_t        a;
    addr_t        mst_addr;
    data_t        d;
    axi_resp_e    resp;
    remap_entry_t e;
    logic         r1_done;
    logic         got_ar2;
    a = 32'h1000_0300;
    d = $random(seed);
    e = entry_of(32'h1000_0000, 32'hF000_0000, 32'h9000_0000);
    write_word(a, d, mst_addr, resp);
    check_addr(mst_addr, expected_addr(a), "AW");
    check_resp(resp, resp_okay, "B");
    r_delay <= 8'd20;
    @(posedge clk);
    slv_req.ar       <= '{id: 4'h2, addr: a, len: 8'd0};
    slv_req.ar_valid <= 1'b1;
    do begin
      @(posedge clk);
    end while (!slv_rsp.ar_ready);
    check_addr(mst_req.ar.addr, expected_addr(a), "held AR");
    slv_req.ar_valid <= 1'b0;
    cfg_we    <= 1'b1;
    cfg_idx   <= 2'd0;
    cfg_entry <= e;
    @(posedge clk);
    cfg_we <= 1'b0;
    @(posedge clk);
    if (!cfg_busy) begin
      proto_errs++;
      $display("Protocol failure: cfg busy did not rise after the strobe");
    end
    model_update(0, e);
    // Second read waits behind the hold
    slv_req.ar       <= '{id: 4'h3, addr: a, len: 8'd0};
    slv_req.ar_valid <= 1'b1;
    r1_done = 1'b0;
    got_ar2 = 1'b0;
    while (!got_ar2) begin
      @(posedge clk);
      if (slv_rsp.r_valid && slv_rsp.r.last) begin
        r1_done = 1'b1;
        check_data(slv_rsp.r.data, d, "held R");
      end
      if (!cfg_busy && !r1_done) begin
        proto_errs++;
        $display("Protocol failure: cfg busy fell before the outstanding read finished");
      end
      if (slv_req.ar_valid && slv_rsp.ar_ready) begin
        if (cfg_busy) begin
          proto_errs++;
          $display("Protocol failure: AR accepted on the slave side while busy");
        end
        check_addr(mst_req.ar.addr, expected_addr(a), "AR after update");
        slv_req.ar_valid <= 1'b0;
        got_ar2 = 1'b1;
      end
    end
    do begin
      @(posedge clk);
    end while (!(slv_rsp.r_valid && slv_rsp.r.last));
    check_data(slv_rsp.r.data, d, "R after update");
    check_resp(slv_rsp.r.resp, resp_okay, "R after update");
    r_delay <= 8'd0;
  endtask

  task automatic random_region_test();
    addr_t mask;
    addr_t a;
    int    k;
    for (int i = 0; i < num_regions; i++) begin
      mask = 32'hF000_0000 | (32'h0FF0_0000 & $random(seed));
      program_region(i, entry_of($random(seed) & mask, mask, $random(seed)));
    end
    for (int n = 0; n < 40; n++) begin
      k = $random(seed) & 3;
      // Half the addresses aimed into a region, half anywhere
      if ($random(seed) & 1) begin
        a = m_base[k] | ($random(seed) & ~m_mask[k]);
      end else begin
        a = $random(seed);
      end
      verify_roundtrip(a & 32'hFFFF_FFFC, $random(seed));
    end
  endtask

  initial begin
    rst       = 1'b1;
    slv_req   = '0;
    cfg_we    = 1'b0;
    cfg_idx   = '0;
    cfg_entry = '0;
    r_delay   = 8'd0;
    for (int i = 0; i < num_regions; i++) begin
      m_valid[i] = 1'b0;
    end
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    slv_req.b_ready <= 1'b1;
    slv_req.r_ready <= 1'b1;
    @(posedge clk);
    if (cfg_busy !== 1'b0 || mst_req.aw_valid !== 1'b0 || mst_req.ar_valid !== 1'b0) begin
      proto_errs++;
      $display("Protocol failure: busy or a master valid is high after reset");
    end
    passthrough_test();
    single_region_test();
    overlap_test();
    update_under_load_test();
    random_region_test();
    repeat (4) @(posedge clk);
    $display("Errors: address %0d, data %0d, response %0d, timing %0d, protocol %0d",
             addr_errs, data_errs, resp_errs, cycle_errs, proto_errs);
    if (addr_errs + data_errs + resp_errs + cycle_errs + proto_errs == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- filelist.f
src/axi_remap_pkg.sv
src/axi_modify_address.sv
src/axi_remap_table.sv
src/axi_txn_tracker.sv
src/axi_remap_ctrl.sv
src/axi_remap_top.sv
test/axi_remap_mem.sv
test/axi_remap_tb.sv
